/* Makefile */
SRCS := $(filter-out +%,$(shell cat src.f)) goose_render_config.svh

obj_dir/Vtb_goose_render: src.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_goose_render -f src.f

run: obj_dir/Vtb_goose_render
	./obj_dir/Vtb_goose_render > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q '\*\*\* FAILED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* goose_render_config.svh */
// Screen geometry, sprite sizes and scroll constants shared by the goose renderer stages
`ifndef GOOSE_RENDER_CONFIG_SVH
`define GOOSE_RENDER_CONFIG_SVH

// Screen
`define SCREEN_W        640
`define FLOOR_Y         240

// Goose occupies one 32 pixel column block, doubled from a 16x16 ROM
`define GOOSE_X_BLOCK   2
`define GOOSE_H         32
`define GOOSE_BASE_Y    (`FLOOR_Y - `GOOSE_H)

// Obstacles sit on the floor
`define OBS_W           40
`define OBS_H           48
`define OBS_TOP         (`FLOOR_Y - `OBS_H)
`define OBS_SPACING     200

// Lit span inside each 16 pixel dot period
`define DOT_FIRST       2
`define DOT_LAST        5

`endif

/* goose_render_golden.txt */
# test haddr vaddr scroll jump obstacles game_over blink display_on, then expected R G B collision
# All fields hex, one pixel per line, streamed back to back
1 064 064 000 00 0 0 1 1 0 3 3 0
1 064 0fa 000 00 0 0 1 1 1 1 1 0
1 003 0f0 000 00 0 0 1 1 2 2 2 0
1 005 0f0 000 00 0 0 1 1 2 2 2 0
1 001 0f0 000 00 0 0 1 1 1 1 1 0
1 006 0f0 000 00 0 0 1 1 1 1 1 0
1 006 0f0 00c 00 0 0 1 1 2 2 2 0
1 003 0f0 00c 00 0 0 1 1 1 1 1 0
1 064 064 000 00 0 0 1 0 0 0 0 0
2 04a 0e8 000 00 0 0 1 1 2 2 1 0
2 045 0e8 000 00 0 0 1 1 2 2 1 0
2 043 0e8 000 00 0 0 1 1 0 3 3 0
2 05e 0d6 000 00 0 0 1 1 3 2 1 0
2 056 0d4 000 00 0 0 1 1 0 0 0 0
2 048 0ee 000 00 0 0 1 1 0 0 0 0
2 04a 0d8 000 10 0 0 1 1 2 2 1 0
2 04a 0e8 000 10 0 0 1 1 0 3 3 0
2 04a 0e8 000 00 0 0 0 1 0 3 3 0
3 04a 0e8 000 00 0 1 1 1 2 0 0 0
3 05e 0d6 000 00 0 1 1 1 2 0 0 0
3 043 0e8 000 00 0 1 1 1 0 3 3 0
4 028 0dc 258 00 1 0 1 1 0 0 0 0
4 032 0dc 258 00 1 0 1 1 3 2 0 0
4 032 0c1 258 00 1 0 1 1 0 0 0 0
4 032 0bf 258 00 1 0 1 1 0 3 3 0
4 032 0dc 258 00 6 0 1 1 0 3 3 0
4 104 0dc 258 00 2 0 1 1 3 2 0 0
4 1b8 0dc 258 00 4 0 1 1 0 0 0 0
4 005 0dc 28a 00 1 0 1 1 3 2 0 0
4 01d 0dc 28a 00 1 0 1 1 0 0 0 0
5 04a 0e8 258 00 1 0 1 1 2 2 1 1
5 04a 0e8 258 00 1 1 1 1 2 0 0 1
5 040 0e8 258 00 1 0 1 1 3 2 0 0
5 04a 0e8 258 00 1 0 0 1 3 2 0 0
5 04a 0e8 258 00 1 0 1 0 0 0 0 0
5 04a 0e8 258 00 6 0 1 1 2 2 1 0
5 04a 0a8 258 40 1 0 1 1 2 2 1 0

/* goose_render_pkg.sv */
// Colour index, RGB and coordinate types plus the palette lookup used by the renderer
package goose_render_pkg;

    typedef enum logic [2:0] {
        COLOR_TRANSPARENT = 3'd0,
        COLOR_GOOSE_BODY  = 3'd1,
        COLOR_BLACK       = 3'd2,
        COLOR_BEAK        = 3'd3,
        COLOR_GOLD        = 3'd4,
        COLOR_WHITE       = 3'd5,
        COLOR_RED         = 3'd6
    } color_idx_t;

    typedef struct packed {
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
    } rgb_t;

    typedef logic [9:0] coord_t;
    typedef logic [10:0] scroll_t;

    function automatic rgb_t palette(input color_idx_t idx);
        rgb_t c;
        case (idx)
            COLOR_GOOSE_BODY: c = '{r: 2'd2, g: 2'd2, b: 2'd1};
            COLOR_BLACK:      c = '{r: 2'd0, g: 2'd0, b: 2'd0};
            COLOR_BEAK:       c = '{r: 2'd3, g: 2'd2, b: 2'd1};
            COLOR_GOLD:       c = '{r: 2'd3, g: 2'd2, b: 2'd0};
            COLOR_WHITE:      c = '{r: 2'd3, g: 2'd3, b: 2'd3};
            COLOR_RED:        c = '{r: 2'd2, g: 2'd0, b: 2'd0};
            default:          c = '0;
        endcase
        return c;
    endfunction

endpackage

/* goose_render_top.sv */
// Goose runner pixel renderer, two-stage pipeline from screen position to colour
`timescale 1ns/100ps

module goose_render_top (
    input  logic                      clk,
    input  logic                      sys_rst,
    input  goose_render_pkg::coord_t  haddr,
    input  goose_render_pkg::coord_t  vaddr,
    input  goose_render_pkg::scroll_t scrolladdr,
    input  logic [6:0]                jump_pos,
    input  logic [2:0]                obstacle_active,
    input  logic                      game_over,
    input  logic                      game_start_blink,
    input  logic                      display_on,
    output logic [1:0]                R,
    output logic [1:0]                G,
    output logic [1:0]                B,
    output logic                      collision
);

    logic                   sky;
    logic                   floor;
    logic                   dots;
    logic                   goose;
    logic [2:0]             obs_hit;
    goose_render_pkg::rgb_t goose_rgb;
    goose_render_pkg::rgb_t obs0_rgb;
    goose_render_pkg::rgb_t obs1_rgb;
    goose_render_pkg::rgb_t obs2_rgb;

    layer_stage i_layer_stage (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .haddr            (haddr),
        .vaddr            (vaddr),
        .scrolladdr       (scrolladdr),
        .jump_pos         (jump_pos),
        .obstacle_active  (obstacle_active),
        .game_over        (game_over),
        .game_start_blink (game_start_blink),
        .display_on       (display_on),
        .sky              (sky),
        .floor            (floor),
        .dots             (dots),
        .goose            (goose),
        .obs_hit          (obs_hit),
        .goose_rgb        (goose_rgb),
        .obs0_rgb         (obs0_rgb),
        .obs1_rgb         (obs1_rgb),
        .obs2_rgb         (obs2_rgb)
    );

    mixer_stage i_mixer_stage (
        .clk       (clk),
        .sys_rst   (sys_rst),
        .sky       (sky),
        .floor     (floor),
        .dots      (dots),
        .goose     (goose),
        .obs_hit   (obs_hit),
        .goose_rgb (goose_rgb),
        .obs0_rgb  (obs0_rgb),
        .obs1_rgb  (obs1_rgb),
        .obs2_rgb  (obs2_rgb),
        .R         (R),
        .G         (G),
        .B         (B),
        .collision (collision)
    );

endmodule

/* goose_sprite.sv */
// Goose ROM lookup at 2x scale with jump offset, blink gating and game-over recolour
`timescale 1ns/100ps
`include "goose_render_config.svh"

module goose_sprite (
    input  goose_render_pkg::coord_t     haddr,
    input  goose_render_pkg::coord_t     vaddr,
    input  logic [6:0]                   jump_pos,
    input  logic                         game_start_blink,
    input  logic                         game_over,
    output goose_render_pkg::color_idx_t pixel
);

    localparam logic [10:0] BASE_Y = 11'(`GOOSE_BASE_Y);
    localparam logic [10:0] HEIGHT = 11'(`GOOSE_H);
    localparam logic [4:0]  X_BLOCK = 5'(`GOOSE_X_BLOCK);

    // 16x16 sprite, 3 bits per pixel, leftmost pixel in the top bits
    localparam logic [47:0] GOOSE_ROM [16] = '{
        48'b000_000_000_000_000_000_000_000_000_000_000_000_000_000_000_000,
        48'b000_000_000_000_000_000_000_000_000_000_000_000_000_000_000_000,
        48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_000,
        48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_011,
        48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_011,
        48'b000_000_000_000_000_000_000_000_000_000_010_010_010_010_010_011,
        48'b000_000_000_000_000_000_000_000_000_000_010_010_010_000_000_000,
        48'b000_000_000_000_000_000_000_000_000_000_010_010_010_000_000_000,
        48'b000_000_000_000_000_000_000_000_000_000_010_010_010_000_000_000,
        48'b000_000_000_000_000_000_000_000_000_000_010_010_010_000_000_000,
        48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000,
        48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000,
        48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000,
        48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000,
        48'b000_000_001_001_001_001_001_001_001_001_001_001_001_000_000_000,
        48'b000_000_000_000_010_010_000_000_000_010_010_000_000_000_000_000
    };

    logic [10:0] vaddr_ext;
    logic [10:0] goose_y;
    logic [10:0] dy;
    logic        in_x;
    logic        in_y;
    logic [3:0]  rom_x;
    logic [3:0]  rom_y;
    logic [47:0] row_bits;
    logic [5:0]  bit_lsb;
    logic [2:0]  raw_idx;

    assign vaddr_ext = {1'b0, vaddr};
    assign goose_y = BASE_Y - {4'd0, jump_pos};

    // Rows above the sprite wrap to a large offset and fail the height check
    assign dy = vaddr_ext - goose_y;
    assign in_y = (dy < HEIGHT);
    assign in_x = (haddr[9:5] == X_BLOCK);

    // Halve the offset for the 2x scale
    assign rom_x = haddr[4:1];
    assign rom_y = dy[4:1];

    assign row_bits = GOOSE_ROM[rom_y];
    assign bit_lsb = 6'((4'd15 - rom_x) * 3);
    assign raw_idx = row_bits[bit_lsb +: 3];

    always_comb begin
        if (!(in_x && in_y && game_start_blink) || raw_idx == 3'd0) begin
            pixel = goose_render_pkg::COLOR_TRANSPARENT;
        end else if (game_over) begin
            pixel = goose_render_pkg::COLOR_RED;
        end else begin
            pixel = goose_render_pkg::color_idx_t'(raw_idx);
        end
    end

endmodule

/* layer_stage.sv */
// First pixel stage: decides background, goose and obstacle layers and registers them
`timescale 1ns/100ps
`include "goose_render_config.svh"

module layer_stage (
    input  logic                      clk,
    input  logic                      sys_rst,
    input  goose_render_pkg::coord_t  haddr,
    input  goose_render_pkg::coord_t  vaddr,
    input  goose_render_pkg::scroll_t scrolladdr,
    input  logic [6:0]                jump_pos,
    input  logic [2:0]                obstacle_active,
    input  logic                      game_over,
    input  logic                      game_start_blink,
    input  logic                      display_on,
    output logic                      sky,
    output logic                      floor,
    output logic                      dots,
    output logic                      goose,
    output logic [2:0]                obs_hit,
    output goose_render_pkg::rgb_t    goose_rgb,
    output goose_render_pkg::rgb_t    obs0_rgb,
    output goose_render_pkg::rgb_t    obs1_rgb,
    output goose_render_pkg::rgb_t    obs2_rgb
);

    localparam logic [10:0] FLOOR_Y = 11'(`FLOOR_Y);
    localparam logic [3:0]  DOT_FIRST = 4'(`DOT_FIRST);
    localparam logic [3:0]  DOT_LAST = 4'(`DOT_LAST);

    logic [10:0]                  vaddr_ext;
    logic [10:0]                  dot_pos;
    logic                         above_floor;
    logic                         dot_lit;
    goose_render_pkg::color_idx_t goose_px;
    logic [2:0]                   obs_hit_c;
    goose_render_pkg::rgb_t       obs_rgb_c [3];

    goose_sprite i_goose_sprite (
        .haddr            (haddr),
        .vaddr            (vaddr),
        .jump_pos         (jump_pos),
        .game_start_blink (game_start_blink),
        .game_over        (game_over),
        .pixel            (goose_px)
    );

    for (genvar i = 0; i < 3; i++) begin : g_obs
        obstacle_sprite #(
            .SLOT (i)
        ) i_obstacle_sprite (
            .haddr      (haddr),
            .vaddr      (vaddr),
            .scrolladdr (scrolladdr),
            .enable     (obstacle_active[i]),
            .hit        (obs_hit_c[i]),
            .rgb        (obs_rgb_c[i])
        );
    end

    assign vaddr_ext = {1'b0, vaddr};
    assign above_floor = (vaddr_ext < FLOOR_Y);

    // Dots scroll with the world, one row high
    assign dot_pos = {1'b0, haddr} + scrolladdr;
    assign dot_lit = (vaddr_ext == FLOOR_Y) && (dot_pos[3:0] >= DOT_FIRST) &&
                     (dot_pos[3:0] <= DOT_LAST);

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            sky <= 1'b0;
            floor <= 1'b0;
            dots <= 1'b0;
            goose <= 1'b0;
            obs_hit <= 3'b000;
            goose_rgb <= '0;
            obs0_rgb <= '0;
            obs1_rgb <= '0;
            obs2_rgb <= '0;
        end else begin
            // Blanking clears every layer here
            sky <= display_on && above_floor;
            floor <= display_on && !above_floor;
            dots <= display_on && dot_lit;
            goose <= display_on && (goose_px != goose_render_pkg::COLOR_TRANSPARENT);
            obs_hit <= display_on ? obs_hit_c : 3'b000;
            goose_rgb <= goose_render_pkg::palette(goose_px);
            obs0_rgb <= obs_rgb_c[0];
            obs1_rgb <= obs_rgb_c[1];
            obs2_rgb <= obs_rgb_c[2];
        end
    end

endmodule

/* mixer_stage.sv */
// Second pixel stage: fixed-priority layer compositing and registered collision flag
`timescale 1ns/100ps

module mixer_stage (
    input  logic                   clk,
    input  logic                   sys_rst,
    input  logic                   sky,
    input  logic                   floor,
    input  logic                   dots,
    input  logic                   goose,
    input  logic [2:0]             obs_hit,
    input  goose_render_pkg::rgb_t goose_rgb,
    input  goose_render_pkg::rgb_t obs0_rgb,
    input  goose_render_pkg::rgb_t obs1_rgb,
    input  goose_render_pkg::rgb_t obs2_rgb,
    output logic [1:0]             R,
    output logic [1:0]             G,
    output logic [1:0]             B,
    output logic                   collision
);

    localparam goose_render_pkg::rgb_t DOT_RGB = '{r: 2'd2, g: 2'd2, b: 2'd2};
    localparam goose_render_pkg::rgb_t FLOOR_RGB = '{r: 2'd1, g: 2'd1, b: 2'd1};
    localparam goose_render_pkg::rgb_t SKY_RGB = '{r: 2'd0, g: 2'd3, b: 2'd3};

    goose_render_pkg::rgb_t mix;

    // Goose on top, lower obstacle slots over higher ones, background last
    always_comb begin
        if (goose) begin
            mix = goose_rgb;
        end else if (obs_hit[0]) begin
            mix = obs0_rgb;
        end else if (obs_hit[1]) begin
            mix = obs1_rgb;
        end else if (obs_hit[2]) begin
            mix = obs2_rgb;
        end else if (dots) begin
            mix = DOT_RGB;
        end else if (floor) begin
            mix = FLOOR_RGB;
        end else if (sky) begin
            mix = SKY_RGB;
        end else begin
            mix = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            R <= 2'b00;
            G <= 2'b00;
            B <= 2'b00;
            collision <= 1'b0;
        end else begin
            R <= mix.r;
            G <= mix.g;
            B <= mix.b;
            collision <= goose && (|obs_hit);
        end
    end

endmodule

/* obstacle_sprite.sv */
// One scrolling obstacle: position from scroll and slot, black frame over gold fill
`timescale 1ns/100ps
`include "goose_render_config.svh"

module obstacle_sprite #(
    parameter int SLOT = 0
) (
    input  goose_render_pkg::coord_t  haddr,
    input  goose_render_pkg::coord_t  vaddr,
    input  goose_render_pkg::scroll_t scrolladdr,
    input  logic                      enable,
    output logic                      hit,
    output goose_render_pkg::rgb_t    rgb
);

    localparam logic [10:0] SCREEN_W = 11'(`SCREEN_W);
    localparam logic [10:0] OFFSET = 11'(SLOT * `OBS_SPACING);
    localparam logic [10:0] WIDTH = 11'(`OBS_W);
    localparam logic [10:0] TOP = 11'(`OBS_TOP);
    localparam logic [10:0] FLOOR_Y = 11'(`FLOOR_Y);

    logic [10:0] vaddr_ext;
    logic [10:0] left_x;
    logic [10:0] local_x;
    logic [10:0] local_y;
    logic        in_rows;
    logic        frame;

    assign vaddr_ext = {1'b0, vaddr};

    // Enters at the right edge and moves left as scroll grows
    assign left_x = SCREEN_W - scrolladdr + OFFSET;

    // Modulo 2048 so a partly off-screen obstacle still shows its right part
    assign local_x = {1'b0, haddr} - left_x;
    assign local_y = vaddr_ext - TOP;

    assign in_rows = (vaddr_ext >= TOP) && (vaddr_ext < FLOOR_Y);
    assign hit = enable && in_rows && (local_x < WIDTH);

    // Two rows on top, one column each side
    assign frame = (local_x == 11'd0) || (local_x == WIDTH - 11'd1) || (local_y <= 11'd1);

    always_comb begin
        if (!hit) begin
            rgb = goose_render_pkg::palette(goose_render_pkg::COLOR_TRANSPARENT);
        end else if (frame) begin
            rgb = goose_render_pkg::palette(goose_render_pkg::COLOR_BLACK);
        end else begin
            rgb = goose_render_pkg::palette(goose_render_pkg::COLOR_GOLD);
        end
    end

endmodule

/* src.f */
+incdir+.
goose_render_pkg.sv
goose_sprite.sv
obstacle_sprite.sv
layer_stage.sv
mixer_stage.sv
goose_render_top.sv
tb_goose_render_assert.sv
tb_goose_render.sv

/* tb_goose_render.sv */
// Testbench for the goose renderer, streams golden pixel vectors and checks them two cycles later
`timescale 1ns/100ps

module tb_goose_render;

    localparam int RST_CYCLES = 16;

    logic        clk;
    logic        sys_rst;
    logic [9:0]  haddr;
    logic [9:0]  vaddr;
    logic [10:0] scrolladdr;
    logic [6:0]  jump_pos;
    logic [2:0]  obstacle_active;
    logic        game_over;
    logic        game_start_blink;
    logic        display_on;
    logic [1:0]  R;
    logic [1:0]  G;
    logic [1:0]  B;
    logic        collision;

    // Inputs packed haddr first, expected packed as R G B collision
    int          vec_test [$];
    logic [43:0] vec_in [$];
    logic [6:0]  vec_exp [$];
    int          exp_q [$];
    int          num_vectors;
    bit          loaded;
    int          mismatches;
    int          file_errors;
    int          tests_passed;
    int          tests_failed;

    goose_render_top i_goose_render_top (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .haddr            (haddr),
        .vaddr            (vaddr),
        .scrolladdr       (scrolladdr),
        .jump_pos         (jump_pos),
        .obstacle_active  (obstacle_active),
        .game_over        (game_over),
        .game_start_blink (game_start_blink),
        .display_on       (display_on),
        .R                (R),
        .G                (G),
        .B                (B),
        .collision        (collision)
    );

    always #5 clk = ~clk;

    function automatic string test_name(input int t);
        case (t)
            1: return "background";
            2: return "goose sprite";
            3: return "game over";
            4: return "obstacles";
            5: return "collision";
            default: return $sformatf("%0d", t);
        endcase
    endfunction

    task automatic compare(input string where, input string sig, input logic [1:0] expected,
                           input logic [1:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s %s expected %h got %h", where, sig, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_outputs(input string where, input logic [6:0] expected);
        compare(where, "R", expected[6:5], R);
        compare(where, "G", expected[4:3], G);
        compare(where, "B", expected[2:1], B);
        compare(where, "collision", {1'b0, expected[0]}, {1'b0, collision});
    endtask

    task automatic apply_inputs(input logic [43:0] v);
        {haddr, vaddr, scrolladdr, jump_pos, obstacle_active, game_over, game_start_blink,
         display_on} = v;
    endtask

    task automatic report_test(input string name, input int errors);
        if (errors == 0) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors);
        end
    endtask

    task automatic read_golden();
        int         fd;
        int         line_no;
        int         n;
        int         t;
        string      line;
        logic [9:0] h;
        logic [9:0] v;
        logic [10:0] s;
        logic [6:0] j;
        logic [2:0] o;
        logic       go;
        logic       bl;
        logic       d;
        logic [1:0] r;
        logic [1:0] g;
        logic [1:0] b;
        logic       c;
        fd = $fopen("goose_render_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden vector file goose_render_golden.txt");
            file_errors++;
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                line_no++;
                if (n != 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                t, h, v, s, j, o, go, bl, d, r, g, b, c);
                    if (n != 13) begin
                        $display("Golden file line %0d is malformed, found %0d of 13 fields",
                                 line_no, n);
                        file_errors++;
                    end else begin
                        vec_test.push_back(t);
                        vec_in.push_back({h, v, s, j, o, go, bl, d});
                        vec_exp.push_back({r, g, b, c});
                    end
                end
            end
            $fclose(fd);
            if (vec_in.size() == 0) begin
                $display("Golden file holds no vectors");
                file_errors++;
            end
        end
    endtask

    initial begin : main
        int    idx;
        int    errors_at_start;
        int    assert_fails;
        string where;
        clk = 1'b0;
        sys_rst = 1'b1;
        // A goose over an obstacle, which must stay hidden while in reset
        apply_inputs({10'h04a, 10'h0e8, 11'h258, 7'h00, 3'b001, 1'b0, 1'b1, 1'b1});
        read_golden();
        num_vectors = vec_in.size();
        loaded = 1'b1;
        errors_at_start = mismatches;
        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_outputs("reset", 7'h00);
        end
        sys_rst = 1'b0;
        for (int n = 0; n < num_vectors + 2; n++) begin
            if (n > 0) begin
                @(negedge clk);
            end
            if (n < 2) begin
                check_outputs("after reset", 7'h00);
                if (n == 1) begin
                    report_test("reset", mismatches - errors_at_start);
                    errors_at_start = mismatches;
                end
            end else begin
                idx = exp_q.pop_front();
                where = $sformatf("vector %0d (test %0d)", idx, vec_test[idx]);
                check_outputs(where, vec_exp[idx]);
                if (idx == num_vectors - 1 || vec_test[idx + 1] != vec_test[idx]) begin
                    report_test(test_name(vec_test[idx]), mismatches - errors_at_start);
                    errors_at_start = mismatches;
                end
            end
            if (n < num_vectors) begin
                apply_inputs(vec_in[n]);
                exp_q.push_back(n);
            end else begin
                apply_inputs('0);
            end
        end
        assert_fails = i_goose_render_top.i_tb_goose_render_assert.fail_count;
        $display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, assert_fails);
        if (tests_failed == 0 && file_errors == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        #((RST_CYCLES + num_vectors + 20) * 10);
        $display("Timeout: the run did not finish in the expected time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule

/* tb_goose_render_assert.sv */
// Concurrent checks on reset and blanking of the renderer outputs, bound to the top level
`timescale 1ns/100ps

module tb_goose_render_assert (
    input logic       clk,
    input logic       sys_rst,
    input logic       display_on,
    input logic [1:0] R,
    input logic [1:0] G,
    input logic [1:0] B,
    input logic       collision
);

    int fail_count = 0;

    a_reset_clears: assert property (@(posedge clk)
        sys_rst |=> (R == 2'd0 && G == 2'd0 && B == 2'd0 && !collision))
        else begin
            $error("outputs not cleared one cycle after reset");
            fail_count++;
        end

    // Two-cycle pipeline, so blanking shows up two edges later
    a_collision_visible: assert property (@(posedge clk) disable iff (sys_rst)
        collision |-> $past(display_on, 2))
        else begin
            $error("collision raised for a blanked pixel");
            fail_count++;
        end

    a_blank_black: assert property (@(posedge clk) disable iff (sys_rst)
        !$past(display_on, 2) |-> (R == 2'd0 && G == 2'd0 && B == 2'd0))
        else begin
            $error("blanked pixel is not black");
            fail_count++;
        end

endmodule

bind goose_render_top tb_goose_render_assert i_tb_goose_render_assert (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .display_on (display_on),
    .R          (R),
    .G          (G),
    .B          (B),
    .collision  (collision)
);
